/* dv/cpu_input.txt */
# program words in hex, one per line, word n at pc 4n
d2824681
d2b579a2
d2d00023
d2ffffe4
8b020025
cb020026
8a0200a7
aa040068
ca0400c9
913ffc2a
d10007eb
9100143f
8b0103ec
d280200d
f80101a5
f81f81a9
f84101ae
f85f81af
--
# events: kind (reg or store), address, value, all in hex
reg 01 0000000000001234
reg 02 00000000abcd0000
reg 03 0000800100000000
reg 04 ffff000000000000
reg 05 00000000abcd1234
reg 06 ffffffff54331234
reg 07 00000000abcd0000
reg 08 ffff800100000000
reg 09 0000ffff54331234
reg 0a 0000000000002233
reg 0b ffffffffffffffff
reg 1f 0000000000001239
reg 0c 0000000000001234
reg 0d 0000000000000100
store 0000000000000110 00000000abcd1234
store 00000000000000f8 0000ffff54331234
reg 0e 00000000abcd1234
reg 0f 0000ffff54331234

/* project.f */
hw/cpu_pkg.sv
hw/iw_decoder_movz.sv
hw/iw_decoder_alu.sv
hw/iw_decoder_mem.sv
hw/control_unit.sv
hw/datapath.sv
hw/cpu_top.sv
dv/cpu_checker.sv
dv/tb_cpu.sv

/* Bender.yml */
package:
  name: legv8_cpu

sources:
  - hw/cpu_pkg.sv
  - hw/iw_decoder_movz.sv
  - hw/iw_decoder_alu.sv
  - hw/iw_decoder_mem.sv
  - hw/control_unit.sv
  - hw/datapath.sv
  - hw/cpu_top.sv
  - target: simulation
    files:
      - dv/cpu_checker.sv
      - dv/tb_cpu.sv

/* dv/tb_cpu.sv */
module tb_cpu
    import cpu_pkg::*;
();

    localparam int max_words = 256; // Program image depth

    logic                      clock;
    logic                      reset;
    logic [instr_width-1:0]    instr;
    logic [word_width-1:0]     pc;
    logic                      halted;
    logic                      rf_write;
    logic [reg_addr_width-1:0] rf_write_addr;
    logic [word_width-1:0]     rf_write_data;
    logic                      ram_write;
    logic [word_width-1:0]     ram_write_addr;
    logic [word_width-1:0]     ram_write_data;
    logic [instr_width-1:0]    image [0:max_words-1];
    logic [word_width-1:0]     next_pc;
    int                        n_words  = 0;
    int                        n_events = 0;
    logic                      loaded   = 1'b0;
    logic                      opened;

    cpu_top i_cpu_top (.*);

    cpu_checker i_checker (
        .clock          (clock),
        .reset          (reset),
        .pc             (pc),
        .halted         (halted),
        .rf_write       (rf_write),
        .rf_write_addr  (rf_write_addr),
        .rf_write_data  (rf_write_data),
        .ram_write      (ram_write),
        .ram_write_addr (ram_write_addr),
        .ram_write_data (ram_write_data)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    // Word at a byte address or all ones past the image end
    function automatic logic [instr_width-1:0] fetch_word(input logic [word_width-1:0] addr);
        if (addr[word_width-1:2] < n_words)
            return image[addr[9:2]];
        return '1; // Unknown opcode halts the core
    endfunction

    // Each supported word writes once in its exec cycle, so a write marks the pc step
    assign next_pc = (rf_write || ram_write) ? pc + 64'd4 : pc;

    always @(posedge clock) begin
        if (reset)
            instr <= fetch_word('0);
        else
            instr <= fetch_word(next_pc); // Word for the pc of the coming cycle
    end

    // Program words, then "--", then kind/address/value events
    task automatic load_test_file(output logic ok);
        int                    fd;
        int                    got;
        logic [8*32-1:0]       tok;
        logic [8*128-1:0]      rest;
        logic [word_width-1:0] addr;
        logic [word_width-1:0] value;
        logic                  in_events;
        in_events = 1'b0;
        ok = 1'b0;
        fd = $fopen("dv/cpu_input.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    got = $fgets(rest, fd); // Skip comment text
                end else if (tok == "--") begin
                    in_events = 1'b1;
                end else if (!in_events) begin
                    got = $sscanf(tok, "%h", image[n_words]);
                    n_words++;
                end else begin
                    got = $fscanf(fd, "%h %h", addr, value);
                    i_checker.add_expected(tok == "store", addr, value);
                    n_events++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Watchdog allows 2 cycles per word plus slack and reset
    initial begin
        wait (loaded);
        repeat (2 * n_words + 50 + 5) @(posedge clock);
        $display("Timeout: core did not halt within %0d cycles", 2 * n_words + 55);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        instr = '0;
        reset = 1'b1;
        load_test_file(opened);
        if (!opened) begin
            $display("Could not open dv/cpu_input.txt for reading");
            $display("Simulation failed");
        end else begin
            loaded = 1'b1;
            repeat (5) @(posedge clock);
            reset <= 1'b0;
            wait (halted === 1'b1);
            repeat (3) @(posedge clock); // Any write after halt counts as extra
            i_checker.report_missing();
            $display("Events %0d/%0d, mismatches %0d, missing %0d, extra %0d, errors %0d",
                     i_checker.n_seen, n_events, i_checker.mismatches, i_checker.missing,
                     i_checker.extra, i_checker.errors);
            if (i_checker.errors == 0)
                $display("Simulation passed");
            else
                $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* dv/cpu_checker.sv */
module cpu_checker
    import cpu_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic [word_width-1:0]     pc,
    input  logic                      halted,
    input  logic                      rf_write,
    input  logic [reg_addr_width-1:0] rf_write_addr,
    input  logic [word_width-1:0]     rf_write_data,
    input  logic                      ram_write,
    input  logic [word_width-1:0]     ram_write_addr,
    input  logic [word_width-1:0]     ram_write_data
);

    localparam int max_events = 256;

    logic                  exp_store [0:max_events-1]; // 1 for a RAM store
    logic [word_width-1:0] exp_addr  [0:max_events-1];
    logic [word_width-1:0] exp_value [0:max_events-1];
    int                    n_expected = 0;
    int                    n_seen     = 0; // Matched or not
    int                    mismatches = 0;
    int                    missing    = 0;
    int                    extra      = 0;
    int                    errors     = 0;
    logic                  halt_seen  = 1'b0; // First halt cycle handled

    function automatic string kind_name(input logic store);
        return store ? "store" : "reg";
    endfunction

    task automatic add_expected(input logic store, input logic [word_width-1:0] addr,
                                input logic [word_width-1:0] value);
        exp_store[n_expected] = store;
        exp_addr[n_expected]  = addr;
        exp_value[n_expected] = value;
        n_expected++;
    endtask

    task automatic check_event(input logic store, input logic [word_width-1:0] addr,
                               input logic [word_width-1:0] value);
        if (n_seen >= n_expected) begin
            $display("Unexpected %s write at %h with %h after the expected events ran out",
                     kind_name(store), addr, value);
            extra++;
            errors++;
        end else if (store !== exp_store[n_seen] || addr !== exp_addr[n_seen]
                     || value !== exp_value[n_seen]) begin
            $display("Error at %0t: event %0d got %s %h = %h, expected %s %h = %h",
                     $time, n_seen, kind_name(store), addr, value,
                     kind_name(exp_store[n_seen]), exp_addr[n_seen], exp_value[n_seen]);
            mismatches++;
            errors++;
        end
        // One write per instruction, so event n belongs to pc 4n
        if (pc !== 64'(4 * n_seen)) begin
            $display("Error at %0t: event %0d seen at pc %h, expected pc %h",
                     $time, n_seen, pc, 64'(4 * n_seen));
            mismatches++;
            errors++;
        end
        n_seen++;
    endtask

    // Unknown word right after the last expected event stops the core at its pc
    task automatic check_halt();
        if (pc !== 64'(4 * n_expected)) begin
            $display("Error at %0t: halted at pc %h, expected pc %h",
                     $time, pc, 64'(4 * n_expected));
            mismatches++;
            errors++;
        end
    endtask

    task automatic report_missing();
        int i;
        for (i = n_seen; i < n_expected; i++) begin
            $display("Expected %s write at %h with %h never appeared",
                     kind_name(exp_store[i]), exp_addr[i], exp_value[i]);
            missing++;
            errors++;
        end
    endtask

    // Write ports are stable before the edge commits them
    always @(posedge clock) begin
        if (!reset) begin
            if (rf_write === 1'b1)
                check_event(1'b0, 64'(rf_write_addr), rf_write_data);
            if (ram_write === 1'b1)
                check_event(1'b1, ram_write_addr, ram_write_data);
            if (halted === 1'b1 && !halt_seen) begin
                halt_seen = 1'b1;
                check_halt();
            end
        end
    end

endmodule

/* hw/cpu_top.sv */
module cpu_top
    import cpu_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic [instr_width-1:0]    instr,
    output logic [word_width-1:0]     pc,
    output logic                      halted,
    output logic                      rf_write,
    output logic [reg_addr_width-1:0] rf_write_addr,
    output logic [word_width-1:0]     rf_write_data,
    output logic                      ram_write,
    output logic [word_width-1:0]     ram_write_addr,
    output logic [word_width-1:0]     ram_write_data
);

    logic [cw_width-1:0]   cw;  // Control word to datapath
    logic [word_width-1:0] k;   // Decoder constant

    control_unit i_control_unit (
        .clock  (clock),
        .reset  (reset),
        .instr  (instr),
        .cw     (cw),
        .k      (k),
        .halted (halted)
    );

    datapath i_datapath (
        .clock          (clock),
        .reset          (reset),
        .cw             (cw),
        .k              (k),
        .pc             (pc),
        .rf_write       (rf_write),
        .rf_write_addr  (rf_write_addr),
        .rf_write_data  (rf_write_data),
        .ram_write      (ram_write),
        .ram_write_addr (ram_write_addr),
        .ram_write_data (ram_write_data)
    );

endmodule

/* hw/datapath.sv */
module datapath
    import cpu_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic [cw_width-1:0]       cw,
    input  logic [word_width-1:0]     k,
    output logic [word_width-1:0]     pc,
    output logic                      rf_write,
    output logic [reg_addr_width-1:0] rf_write_addr,
    output logic [word_width-1:0]     rf_write_data,
    output logic                      ram_write,
    output logic [word_width-1:0]     ram_write_addr,
    output logic [word_width-1:0]     ram_write_data
);

    logic [word_width-1:0]     rf [0:2**reg_addr_width-1];
    logic [word_width-1:0]     ram [0:ram_words-1];
    logic                      alu_en, alu_bs, rf_b_en, rf_w;
    logic                      ram_en, ram_w, pc_en;
    logic [alu_fs_width-1:0]   alu_fs;
    logic [reg_addr_width-1:0] sa, sb, da;
    logic [1:0]                pc_fs;
    logic [word_width-1:0]     rf_a, rf_b;
    logic [word_width-1:0]     b_src, alu_a, alu_b, sum, alu_out;
    logic [word_width-1:0]     ram_out, bus;
    logic [ram_addr_width-1:0] ram_addr;

    // Control word fields
    assign alu_en  = cw[cw_alu_en];
    assign alu_bs  = cw[cw_alu_bs];
    assign alu_fs  = cw[cw_alu_fs +: alu_fs_width];
    assign rf_b_en = cw[cw_rf_b_en];
    assign sa      = cw[cw_rf_sa +: reg_addr_width];
    assign sb      = cw[cw_rf_sb +: reg_addr_width];
    assign da      = cw[cw_rf_da +: reg_addr_width];
    assign rf_w    = cw[cw_rf_w];
    assign ram_en  = cw[cw_ram_en];
    assign ram_w   = cw[cw_ram_w];
    assign pc_en   = cw[cw_pc_en];
    assign pc_fs   = cw[cw_pc_fs +: 2];

    // Register file, XZR forced to zero on read
    assign rf_a = (sa == zero_reg) ? '0 : rf[sa];
    assign rf_b = (sb == zero_reg) ? '0 : rf[sb];

    always_ff @(posedge clock) begin
        if (rf_w)
            rf[da] <= bus;
    end

    // ALU operands with optional inversion
    assign b_src = alu_bs ? k : rf_b;
    assign alu_a = alu_fs[0] ? ~rf_a : rf_a;
    assign alu_b = alu_fs[1] ? ~b_src : b_src;
    assign sum   = alu_a + alu_b + {{(word_width-1){1'b0}}, alu_fs[1]}; // Carry in on ~B

    always_comb begin
        case ({alu_fs[4:2], 2'b00})
            alu_and: alu_out = alu_a & alu_b;
            alu_or:  alu_out = alu_a | alu_b;
            alu_add: alu_out = sum;
            alu_xor: alu_out = alu_a ^ alu_b;
            alu_lsl: alu_out = alu_a << alu_b[5:0];
            alu_lsr: alu_out = alu_a >> alu_b[5:0];
            default: alu_out = '0;
        endcase
    end

    // RAM addressed by ALU result
    assign ram_addr = alu_out[ram_addr_lsb +: ram_addr_width];
    assign ram_out  = ram[ram_addr];

    always_ff @(posedge clock) begin
        if (ram_w)
            ram[ram_addr] <= bus;
    end

    // Shared bus, at most one source enabled
    always_comb begin
        bus = '0;
        if (alu_en)
            bus = alu_out;
        else if (rf_b_en)
            bus = rf_b;
        else if (ram_en)
            bus = ram_out;
        else if (pc_en)
            bus = pc;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else begin
            case (pc_fs)
                pc_inc4: pc <= pc + word_width'(4);
                default: pc <= pc; // Hold
            endcase
        end
    end

    // Observation ports
    assign rf_write       = rf_w;
    assign rf_write_addr  = da;
    assign rf_write_data  = bus;
    assign ram_write      = ram_w;
    assign ram_write_addr = alu_out;
    assign ram_write_data = bus;

    a_bus_onehot0: assert property (@(posedge clock) disable iff (reset)
        $onehot0({alu_en, rf_b_en, ram_en, pc_en}));

    // Any write needs exactly one bus source
    a_write_has_source: assert property (@(posedge clock) disable iff (reset)
        (rf_w || ram_w) |-> $onehot({alu_en, rf_b_en, ram_en, pc_en}));

endmodule

/* hw/control_unit.sv */
module control_unit
    import cpu_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic [instr_width-1:0] instr,
    output logic [cw_width-1:0]    cw,
    output logic [word_width-1:0]  k,
    output logic                   halted
);

    logic [instr_width-1:0] ir;     // Instruction register
    logic [1:0]             state;
    logic [cw_width-1:0]    cw_movz;
    logic [cw_width-1:0]    cw_alu;
    logic [cw_width-1:0]    cw_mem;
    logic [word_width-1:0]  k_movz;
    logic [word_width-1:0]  k_alu;
    logic [word_width-1:0]  k_mem;
    logic                   is_movz;
    logic                   is_alu;
    logic                   is_mem;

    // Opcode classes with one decoder each
    assign is_movz = (ir[31:23] == op_movz);
    assign is_alu  = (ir[31:21] inside {op_add, op_sub, op_and, op_orr, op_eor})
                   || (ir[31:22] inside {op_addi, op_subi});
    assign is_mem  = (ir[31:21] == op_ldur) || (ir[31:21] == op_stur);

    iw_decoder_movz i_dec_movz (.instr(ir), .state(state), .cw(cw_movz), .k(k_movz));
    iw_decoder_alu  i_dec_alu  (.instr(ir), .state(state), .cw(cw_alu),  .k(k_alu));
    iw_decoder_mem  i_dec_mem  (.instr(ir), .state(state), .cw(cw_mem),  .k(k_mem));

    always_comb begin
        cw = '0;
        k  = '0;
        case (state)
            st_fetch: cw[cw_next_state +: 2] = st_exec; // Only move on
            st_exec: begin
                if (is_movz) begin
                    cw = cw_movz;
                    k  = k_movz;
                end else if (is_alu) begin
                    cw = cw_alu;
                    k  = k_alu;
                end else if (is_mem) begin
                    cw = cw_mem;
                    k  = k_mem;
                end else begin
                    cw[cw_next_state +: 2] = st_halt; // Unknown opcode
                end
            end
            default: cw[cw_next_state +: 2] = st_halt; // Stay halted
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset)
            state <= st_fetch;
        else
            state <= cw[cw_next_state +: 2];
    end

    always_ff @(posedge clock) begin
        if (state == st_fetch)
            ir <= instr; // Latch word for current pc
    end

    assign halted = (state == st_halt);

    // Decoders only raise their writes in the execute state
    a_no_write_in_fetch: assert property (@(posedge clock) disable iff (reset)
        state == st_fetch |-> !cw_movz[cw_rf_w] && !cw_alu[cw_rf_w]
                              && !cw_mem[cw_rf_w] && !cw_mem[cw_ram_w]);

endmodule

/* hw/iw_decoder_mem.sv */
module iw_decoder_mem
    import cpu_pkg::*;
(
    input  logic [instr_width-1:0] instr,
    input  logic [1:0]             state,
    output logic [cw_width-1:0]    cw,
    output logic [word_width-1:0]  k
);

    logic [10:0]               op11;
    logic [8:0]                offset;  // Signed byte offset
    logic [reg_addr_width-1:0] rn;      // Base register
    logic [reg_addr_width-1:0] rt;      // Data register
    logic                      exec;
    logic                      is_load;
    logic                      is_store;

    assign op11     = instr[31:21];
    assign offset   = instr[20:12];
    assign rn       = instr[9:5];
    assign rt       = instr[4:0];
    assign exec     = (state == st_exec);
    assign is_load  = (op11 == op_ldur);
    assign is_store = (op11 == op_stur);

    // Sign extend the offset
    assign k = {{(word_width-9){offset[8]}}, offset};

    // ALU forms Rn + k as the RAM address, never drives the bus here
    // LDUR takes the bus from RAM, STUR puts Rt on it through port B
    always_comb begin
        cw = '0;
        cw[cw_alu_en]                  = 1'b0;
        cw[cw_alu_bs]                  = 1'b1;
        cw[cw_alu_fs +: alu_fs_width]  = alu_add;
        cw[cw_rf_b_en]                 = exec & is_store;
        cw[cw_rf_sa +: reg_addr_width] = rn;
        cw[cw_rf_sb +: reg_addr_width] = rt;   // Store data
        cw[cw_rf_da +: reg_addr_width] = rt;   // Load target
        cw[cw_rf_w]                    = exec & is_load;
        cw[cw_ram_en]                  = exec & is_load;
        cw[cw_ram_w]                   = exec & is_store;
        cw[cw_pc_en]                   = 1'b0;
        cw[cw_pc_fs +: 2]              = exec ? pc_inc4 : pc_hold;
        cw[cw_pc_is]                   = 1'b0;
        cw[cw_status_ld]               = 1'b0;
        cw[cw_next_state +: 2]         = exec ? st_fetch : st_exec;
    end

endmodule

/* hw/iw_decoder_alu.sv */
module iw_decoder_alu
    import cpu_pkg::*;
(
    input  logic [instr_width-1:0] instr,
    input  logic [1:0]             state,
    output logic [cw_width-1:0]    cw,
    output logic [word_width-1:0]  k
);

    logic [10:0]               op11;  // R-format opcode
    logic [9:0]                op10;  // I-format opcode
    logic [reg_addr_width-1:0] rm;
    logic [reg_addr_width-1:0] rn;
    logic [reg_addr_width-1:0] rd;
    logic [11:0]               imm12;
    logic                      is_imm;
    logic                      exec;
    logic [alu_fs_width-1:0]   fs;

    assign op11   = instr[31:21];
    assign op10   = instr[31:22];
    assign rm     = instr[20:16];
    assign imm12  = instr[21:10];
    assign rn     = instr[9:5];
    assign rd     = instr[4:0];
    assign exec   = (state == st_exec);
    assign is_imm = (op10 == op_addi) || (op10 == op_subi);

    // Zero-extended immediate for ADDI/SUBI
    assign k = is_imm ? {{(word_width-12){1'b0}}, imm12} : '0;

    always_comb begin
        case (op11)
            op_add:  fs = alu_add;
            op_sub:  fs = alu_sub;
            op_and:  fs = alu_and;
            op_orr:  fs = alu_or;
            op_eor:  fs = alu_xor;
            default: fs = alu_add; // ADDI lands here
        endcase
        if (op10 == op_subi)
            fs = alu_sub;
    end

    always_comb begin
        cw = '0;
        cw[cw_alu_en]                  = exec;   // Result onto bus
        cw[cw_alu_bs]                  = is_imm; // k instead of Rm
        cw[cw_alu_fs +: alu_fs_width]  = fs;
        cw[cw_rf_b_en]                 = 1'b0;
        cw[cw_rf_sa +: reg_addr_width] = rn;
        cw[cw_rf_sb +: reg_addr_width] = is_imm ? zero_reg : rm;
        cw[cw_rf_da +: reg_addr_width] = rd;
        cw[cw_rf_w]                    = exec;
        cw[cw_ram_en]                  = 1'b0;
        cw[cw_ram_w]                   = 1'b0;
        cw[cw_pc_en]                   = 1'b0;
        cw[cw_pc_fs +: 2]              = exec ? pc_inc4 : pc_hold;
        cw[cw_pc_is]                   = 1'b0;
        cw[cw_status_ld]               = 1'b0;
        cw[cw_next_state +: 2]         = exec ? st_fetch : st_exec;
    end

endmodule

/* hw/iw_decoder_movz.sv */
module iw_decoder_movz
    import cpu_pkg::*;
(
    input  logic [instr_width-1:0] instr,
    input  logic [1:0]             state,
    output logic [cw_width-1:0]    cw,
    output logic [word_width-1:0]  k
);

    logic [1:0]                hw;  // Halfword slot
    logic [15:0]               imm;
    logic [reg_addr_width-1:0] rd;
    logic                      exec;

    assign hw   = instr[22:21];
    assign imm  = instr[20:5];
    assign rd   = instr[4:0];
    assign exec = (state == st_exec);

    // Immediate moved up by 16 * hw, everything else zero
    assign k = {{(word_width-16){1'b0}}, imm} << {hw, 4'b0000};

    // Rd = XZR | k, result goes out over the bus
    always_comb begin
        cw = '0;
        cw[cw_alu_en]                   = exec;
        cw[cw_alu_bs]                   = 1'b1;    // B side from k
        cw[cw_alu_fs +: alu_fs_width]   = alu_or;
        cw[cw_rf_b_en]                  = 1'b0;
        cw[cw_rf_sa +: reg_addr_width]  = zero_reg; // A reads zero
        cw[cw_rf_sb +: reg_addr_width]  = zero_reg; // Not used
        cw[cw_rf_da +: reg_addr_width]  = rd;
        cw[cw_rf_w]                     = exec;
        cw[cw_ram_en]                   = 1'b0;
        cw[cw_ram_w]                    = 1'b0;
        cw[cw_pc_en]                    = 1'b0;
        cw[cw_pc_fs +: 2]               = exec ? pc_inc4 : pc_hold;
        cw[cw_pc_is]                    = 1'b0;
        cw[cw_status_ld]                = 1'b0; // No flags
        cw[cw_next_state +: 2]          = exec ? st_fetch : st_exec;
    end

endmodule

/* hw/cpu_pkg.sv */
package cpu_pkg;

    localparam int word_width     = 64; // Data path width
    localparam int instr_width    = 32;
    localparam int cw_width       = 33; // Control word width
    localparam int reg_addr_width = 5;  // 32 registers
    localparam int alu_fs_width   = 5;

    // Control word fields, msb first, lsb given for multi-bit fields
    localparam int cw_alu_en     = 32; // ALU drives bus
    localparam int cw_alu_bs     = 31; // ALU B from k
    localparam int cw_alu_fs     = 26; // 5 bits
    localparam int cw_rf_b_en    = 25; // RF port B drives bus
    localparam int cw_rf_sa      = 20;
    localparam int cw_rf_sb      = 15;
    localparam int cw_rf_da      = 10;
    localparam int cw_rf_w       = 9;
    localparam int cw_ram_en     = 8;  // RAM drives bus
    localparam int cw_ram_w      = 7;
    localparam int cw_pc_en      = 6;  // PC drives bus
    localparam int cw_pc_fs      = 4;  // 2 bits
    localparam int cw_pc_is      = 3;
    localparam int cw_status_ld  = 2;  // Always 0 here
    localparam int cw_next_state = 0;  // 2 bits

    // ALU function, fs[4:2] picks the operation
    // Bit 1 inverts B and feeds carry in, bit 0 inverts A
    localparam logic [4:0] alu_and = 5'b000_00;
    localparam logic [4:0] alu_or  = 5'b001_00;
    localparam logic [4:0] alu_add = 5'b010_00;
    localparam logic [4:0] alu_xor = 5'b011_00;
    localparam logic [4:0] alu_lsl = 5'b100_00;
    localparam logic [4:0] alu_lsr = 5'b101_00;
    localparam logic [4:0] alu_sub = 5'b010_10; // A + ~B + 1

    localparam logic [1:0] st_fetch = 2'd0;
    localparam logic [1:0] st_exec  = 2'd1;
    localparam logic [1:0] st_halt  = 2'd3;

    localparam logic [1:0] pc_hold = 2'b00;
    localparam logic [1:0] pc_inc4 = 2'b01;

    localparam logic [8:0]  op_movz = 9'b110100101;
    localparam logic [10:0] op_add  = 11'b10001011000;
    localparam logic [10:0] op_sub  = 11'b11001011000;
    localparam logic [10:0] op_and  = 11'b10001010000;
    localparam logic [10:0] op_orr  = 11'b10101010000;
    localparam logic [10:0] op_eor  = 11'b11001010000;
    localparam logic [10:0] op_ldur = 11'b11111000010;
    localparam logic [10:0] op_stur = 11'b11111000000;
    localparam logic [9:0]  op_addi = 10'b1001000100;
    localparam logic [9:0]  op_subi = 10'b1101000100;

    localparam logic [4:0] zero_reg = 5'd31; // Reads as 0

    localparam int ram_words      = 256;
    localparam int ram_addr_lsb   = 3;  // Word addressed, byte offset dropped
    localparam int ram_addr_width = $clog2(ram_words);

endpackage
